//--- include/ccl_consts.svh
`ifndef CCL_CONSTS_SVH
`define CCL_CONSTS_SVH

// frame geometry in pixels
`define CCL_IMG_W 16
`define CCL_IMG_H 12

// label table depth, entry 0 stands for background
`define CCL_MAX_LABELS 64

// smallest component area that gets reported
`define CCL_MIN_AREA 4

// how many of the largest areas are ranked
`define CCL_TOP_N 3

`endif

//--- source/ccl_pkg.sv
`include "ccl_consts.svh"

package ccl_pkg;

    typedef logic [$clog2(`CCL_MAX_LABELS)-1:0] label_t;
    typedef logic [$clog2(`CCL_IMG_W*`CCL_IMG_H+1)-1:0] area_t;  // wide enough for a full frame
    typedef logic [$clog2(`CCL_IMG_W)-1:0] col_t;
    typedef logic [$clog2(`CCL_IMG_H)-1:0] row_t;
    typedef logic [$clog2(`CCL_MAX_LABELS)-1:0] count_t;

    // frame level sequence, one pass per state
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        LABEL,
        RESOLVE,
        MERGE,
        RANK,
        DONE
    } ccl_state_t;

endpackage

//--- source/label_ram.sv
`timescale 1ns/10ps

module label_ram #(
    parameter type T     = logic,
    parameter int  DEPTH = 64
) (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  T                         wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr_a,
    input  logic [$clog2(DEPTH)-1:0] raddr_b,
    output T                         rdata_a,
    output T                         rdata_b
);

    T mem [DEPTH];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= T'(0);
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // both reads are combinational so a write is visible on the next cycle
    assign rdata_a = mem[raddr_a];
    assign rdata_b = mem[raddr_b];

    a_waddr_range: assert property (@(posedge clk_in) disable iff (rst_in)
        we |-> (waddr < DEPTH))
        else $error("write address %0d beyond table depth %0d", waddr, DEPTH);

endmodule

//--- source/scan_counter.sv
`timescale 1ns/10ps
`include "ccl_consts.svh"

module scan_counter
    import ccl_pkg::*;
(
    input  logic       clk_in,
    input  logic       rst_in,
    input  ccl_state_t state,
    input  logic       step,
    output col_t       col,
    output row_t       row,
    output label_t     idx,
    output logic       last_pix,
    output logic       last_idx,
    input  label_t     idx_end
);

    assign last_pix = (col == col_t'(`CCL_IMG_W-1)) && (row == row_t'(`CCL_IMG_H-1));
    assign last_idx = (idx >= idx_end - label_t'(1));  // idx_end of 1 means an empty table

    // each counter wraps on its last step, so the next state starts from the top
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            col <= '0;
            row <= '0;
            idx <= label_t'(1);
        end else begin
            case (state)
                LOAD, LABEL: begin
                    if (step) begin
                        if (col == col_t'(`CCL_IMG_W-1)) begin
                            col <= '0;
                            row <= last_pix ? '0 : row + 1'b1;
                        end else begin
                            col <= col + 1'b1;
                        end
                    end
                end
                RESOLVE, MERGE, RANK: begin
                    if (step) begin
                        idx <= last_idx ? label_t'(1) : idx + 1'b1;  // label 0 is skipped
                    end
                end
                default: begin
                    col <= '0;
                    row <= '0;
                    idx <= label_t'(1);
                end
            endcase
        end
    end

    a_row_range: assert property (@(posedge clk_in) disable iff (rst_in)
        (state inside {LOAD, LABEL}) |-> (row < `CCL_IMG_H))
        else $error("raster row %0d out of frame", row);

endmodule

//--- source/ccl_ctrl.sv
`timescale 1ns/10ps

module ccl_ctrl
    import ccl_pkg::*;
(
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       frame_start,
    input  logic       pix_valid,
    input  logic       pix_done,
    input  logic       last_pix,
    input  logic       last_idx,
    output ccl_state_t state,
    output logic       step,
    output logic       pix_ready,
    output logic       pix_go,
    output logic       rank_clear,
    output logic       busy,
    output logic       done
);

    logic waiting;  // a labeling request is out to the labeler

    assign pix_ready = (state == LOAD);
    assign pix_go    = (state == LABEL) && !waiting;
    assign busy      = (state != IDLE) && (state != DONE);
    assign done      = (state == DONE);

    always_comb begin
        case (state)
            LOAD:                 step = pix_valid;  // pix_ready is high all through LOAD
            LABEL:                step = pix_done;
            RESOLVE, MERGE, RANK: step = 1'b1;       // one table index per cycle
            default:              step = 1'b0;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state      <= IDLE;
            waiting    <= 1'b0;
            rank_clear <= 1'b0;
        end else begin
            // lands on the first LABEL cycle
            rank_clear <= (state == LOAD) && step && last_pix;

            if (pix_go) begin
                waiting <= 1'b1;
            end else if (pix_done) begin
                waiting <= 1'b0;
            end

            case (state)
                IDLE: begin
                    if (frame_start) begin
                        state <= LOAD;
                    end
                end
                LOAD: begin
                    if (step && last_pix) begin
                        state <= LABEL;
                    end
                end
                LABEL: begin
                    if (step && last_pix) begin
                        state <= RESOLVE;
                    end
                end
                RESOLVE: begin
                    if (last_idx) begin
                        state <= MERGE;
                    end
                end
                MERGE: begin
                    if (last_idx) begin
                        state <= RANK;
                    end
                end
                RANK: begin
                    if (last_idx) begin
                        state <= DONE;
                    end
                end
                default: state <= IDLE;  // DONE lasts one cycle
            endcase
        end
    end

    a_done_in_label: assert property (@(posedge clk_in) disable iff (rst_in)
        pix_done |-> (state == LABEL) && waiting)
        else $error("labeler finished a pixel that was never requested");

endmodule

//--- source/neighbor_labeler.sv
`timescale 1ns/10ps
`include "ccl_consts.svh"

module neighbor_labeler
    import ccl_pkg::*;
(
    input  logic       clk_in,
    input  logic       rst_in,
    input  ccl_state_t state,
    input  logic       pix_go,
    input  col_t       col,
    input  row_t       row,
    input  logic       pix_fg,
    input  label_t     idx,
    output logic       pix_done,
    output logic       area_inc,
    output label_t     area_label,
    output label_t     next_label,
    output label_t     root_of_idx,
    output logic       idx_is_root
);

    label_t     line_buf [`CCL_IMG_W];  // current row left of col, previous row from col on
    label_t     west_q;
    label_t     nw_q;                   // previous row at col-1, saved before it is overwritten
    label_t     nb [4];                 // w, nw, n, ne
    logic       active;
    logic       finish;
    logic [1:0] slot;
    label_t     chase;                  // label being walked up to its root
    label_t     root;                   // smallest root so far, 0 for none
    logic       eq_we;
    label_t     eq_waddr;
    label_t     eq_wdata;
    label_t     eq_raddr_a;
    label_t     eq_rd_a;
    label_t     eq_rd_b;
    logic       at_root;
    logic       union_we;
    logic       alloc;
    label_t     lbl;
    logic       pix_commit;

    // image edges read as background
    always_comb begin
        nb[0] = (col != '0) ? west_q : '0;
        nb[1] = (col != '0 && row != '0) ? nw_q : '0;
        nb[2] = (row != '0) ? line_buf[col] : '0;
        nb[3] = (row != '0 && col != col_t'(`CCL_IMG_W-1)) ? line_buf[col + 1'b1] : '0;
    end

    assign at_root  = (eq_rd_a == chase);  // entry 0 points to itself, so empty slots pass too
    assign union_we = active && !finish && at_root && chase != '0 && root != '0 && chase != root;
    assign alloc    = finish && (root == '0);
    assign lbl      = alloc ? next_label : root;
    assign pix_commit = (pix_go && !pix_fg) || finish;

    assign area_inc    = finish;
    assign area_label  = lbl;
    assign root_of_idx = eq_rd_a;
    assign idx_is_root = (eq_rd_a == idx) && (idx < next_label);

    assign eq_raddr_a = (state == LABEL) ? chase : idx;

    always_comb begin
        eq_we    = 1'b0;
        eq_waddr = idx;
        eq_wdata = eq_rd_b;  // root of the parent, already flat since it is lower
        if (state == RESOLVE) begin
            eq_we = (idx < next_label);
        end else if (alloc) begin
            eq_we    = 1'b1;
            eq_waddr = next_label;
            eq_wdata = next_label;
        end else if (union_we) begin
            eq_we    = 1'b1;  // the larger root always points down
            eq_waddr = (chase < root) ? root : chase;
            eq_wdata = (chase < root) ? chase : root;
        end
    end

    label_ram #(
        .T     (label_t),
        .DEPTH (`CCL_MAX_LABELS)
    ) eq_tbl (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .we      (eq_we),
        .waddr   (eq_waddr),
        .wdata   (eq_wdata),
        .raddr_a (eq_raddr_a),
        .raddr_b (eq_rd_a),
        .rdata_a (eq_rd_a),
        .rdata_b (eq_rd_b)
    );

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            active     <= 1'b0;
            finish     <= 1'b0;
            pix_done   <= 1'b0;
            next_label <= label_t'(1);
            slot       <= '0;
            chase      <= '0;
            root       <= '0;
        end else begin
            pix_done <= pix_commit;
            if (state == LOAD) begin
                next_label <= label_t'(1);
            end else if (alloc) begin
                next_label <= next_label + 1'b1;
            end

            if (pix_go && pix_fg) begin
                active <= 1'b1;
                slot   <= '0;
                chase  <= nb[0];
                root   <= '0;
            end else if (finish) begin
                active <= 1'b0;
                finish <= 1'b0;
            end else if (active) begin
                if (at_root) begin
                    if (chase != '0 && (root == '0 || chase < root)) begin
                        root <= chase;
                    end
                    if (slot == 2'd3) begin
                        finish <= 1'b1;
                    end else begin
                        slot  <= slot + 1'b1;
                        chase <= nb[slot + 2'd1];
                    end
                end else begin
                    chase <= eq_rd_a;  // one step up per cycle
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (pix_commit) begin
            nw_q          <= line_buf[col];
            line_buf[col] <= finish ? lbl : '0;
            west_q        <= finish ? lbl : '0;
        end
    end

    a_label_cap: assert property (@(posedge clk_in) disable iff (rst_in)
        alloc |-> (next_label != label_t'(`CCL_MAX_LABELS-1)))
        else $error("label table full at row %0d col %0d", row, col);

endmodule

//--- source/area_accum.sv
`timescale 1ns/10ps
`include "ccl_consts.svh"

module area_accum
    import ccl_pkg::*;
(
    input  logic       clk_in,
    input  logic       rst_in,
    input  ccl_state_t state,
    input  logic       area_inc,
    input  label_t     area_label,
    input  label_t     idx,
    input  label_t     root_of_idx,
    output area_t      idx_area
);

    logic   tbl_clr;
    logic   tbl_we;
    label_t tbl_waddr;
    area_t  tbl_wdata;
    label_t tbl_raddr_a;
    area_t  tbl_rd_a;
    area_t  tbl_rd_b;

    assign tbl_clr     = rst_in || (state == LOAD);  // counts are wiped while the mask streams in
    assign tbl_raddr_a = (state == LABEL) ? area_label : idx;

    always_comb begin
        if (state == MERGE) begin
            // fold a non-root count onto its root
            tbl_we    = (root_of_idx != idx);
            tbl_waddr = root_of_idx;
            tbl_wdata = tbl_rd_a + tbl_rd_b;
        end else begin
            tbl_we    = (state == LABEL) && area_inc;
            tbl_waddr = area_label;
            tbl_wdata = tbl_rd_a + 1'b1;
        end
    end

    // folded entries read back as zero
    assign idx_area = (root_of_idx == idx) ? tbl_rd_a : '0;

    label_ram #(
        .T     (area_t),
        .DEPTH (`CCL_MAX_LABELS)
    ) area_tbl (
        .clk_in  (clk_in),
        .rst_in  (tbl_clr),
        .we      (tbl_we),
        .waddr   (tbl_waddr),
        .wdata   (tbl_wdata),
        .raddr_a (tbl_raddr_a),
        .raddr_b (root_of_idx),
        .rdata_a (tbl_rd_a),
        .rdata_b (tbl_rd_b)
    );

endmodule

//--- source/blob_ranker.sv
`timescale 1ns/10ps
`include "ccl_consts.svh"

module blob_ranker
    import ccl_pkg::*;
(
    input  logic       clk_in,
    input  logic       rst_in,
    input  ccl_state_t state,
    input  logic       rank_clear,
    input  logic       idx_is_root,
    input  area_t      idx_area,
    output count_t     blob_count,
    output area_t      top_area [`CCL_TOP_N]
);

    logic  keep;
    area_t top_nxt [`CCL_TOP_N];

    assign keep = (state == RANK) && idx_is_root && (idx_area >= area_t'(`CCL_MIN_AREA));

    // insert into the descending list, everything below the slot moves down one
    always_comb begin
        top_nxt = top_area;
        if (idx_area > top_area[0]) begin
            top_nxt[0] = idx_area;
        end
        for (int i = 1; i < `CCL_TOP_N; i++) begin
            if (idx_area > top_area[i]) begin
                top_nxt[i] = (idx_area > top_area[i-1]) ? top_area[i-1] : idx_area;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in || rank_clear) begin
            blob_count <= '0;
            for (int i = 0; i < `CCL_TOP_N; i++) begin
                top_area[i] <= '0;
            end
        end else if (keep) begin
            blob_count <= blob_count + 1'b1;
            top_area   <= top_nxt;
        end
    end

endmodule

//--- source/ccl_top.sv
`timescale 1ns/10ps
`include "ccl_consts.svh"

module ccl_top
    import ccl_pkg::*;
(
    input  logic   clk_in,
    input  logic   rst_in,
    input  logic   frame_start,
    input  logic   pix_valid,
    input  logic   pix_mask,
    output logic   pix_ready,
    output logic   busy,
    output logic   done,
    output count_t blob_count,
    output area_t  top_area [`CCL_TOP_N]
);

    localparam int PIX_N  = `CCL_IMG_W * `CCL_IMG_H;
    localparam int PIX_AW = $clog2(PIX_N);

    ccl_state_t        state;
    logic              step;
    logic              pix_go;
    logic              pix_done;
    logic              rank_clear;
    logic              last_pix;
    logic              last_idx;
    col_t              col;
    row_t              row;
    label_t            idx;
    logic              pix_fg;
    logic              area_inc;
    label_t            area_label;
    label_t            next_label;
    label_t            root_of_idx;
    logic              idx_is_root;
    area_t             idx_area;
    logic [PIX_AW-1:0] pix_addr;

    // raster address, shared by the load write and the label read
    assign pix_addr = PIX_AW'(row) * PIX_AW'(`CCL_IMG_W) + PIX_AW'(col);

    ccl_ctrl ctrl_i (.*);

    scan_counter scan_i (
        .idx_end (next_label),
        .*
    );

    label_ram #(
        .T     (logic),
        .DEPTH (PIX_N)
    ) mask_store_i (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .we      (pix_valid && pix_ready),
        .waddr   (pix_addr),
        .wdata   (pix_mask),
        .raddr_a (pix_addr),
        .raddr_b (pix_addr),
        .rdata_a (pix_fg),
        .rdata_b ()
    );

    neighbor_labeler labeler_i (.*);

    area_accum area_i (.*);

    blob_ranker ranker_i (.*);

endmodule

//--- sim/tb_ccl.sv
`timescale 1ns/10ps
`include "ccl_consts.svh"

module tb_ccl
    import ccl_pkg::*;
();

    localparam int PIX_N      = `CCL_IMG_W * `CCL_IMG_H;
    localparam int NUM_FRAMES = 31;                  // frames sent over all six tests
    localparam int MAX_CYCLES = NUM_FRAMES * 3000;

    logic   clk_in;
    logic   rst_in;
    logic   frame_start;
    logic   pix_valid;
    logic   pix_mask;
    logic   pix_ready;
    logic   busy;
    logic   done;
    count_t blob_count;
    area_t  top_area [`CCL_TOP_N];

    logic [31:0] rng_state = 32'd66470;
    int cycle_cnt      = 0;
    int err_count      = 0;
    int check_count    = 0;
    int sent_frames    = 0;
    int checked_frames = 0;
    int frame_base     = 0;
    int err_base       = 0;
    int exp_q [$];                                   // count, then three areas, per frame

    ccl_top ccl_top_i (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .frame_start (frame_start),
        .pix_valid   (pix_valid),
        .pix_mask    (pix_mask),
        .pix_ready   (pix_ready),
        .busy        (busy),
        .done        (done),
        .blob_count  (blob_count),
        .top_area    (top_area)
    );

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= MAX_CYCLES);
        $display("timeout: no final result after %0d clock cycles", cycle_cnt);
        $display("SIMULATION FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // sets an h x w block of pixels with its corner at (r0, c0)
    function automatic logic [PIX_N-1:0] add_rect(input logic [PIX_N-1:0] f, input int r0,
                                                  input int c0, input int h, input int w);
        for (int r = r0; r < r0 + h; r++) begin
            for (int c = c0; c < c0 + w; c++) begin
                f[r * `CCL_IMG_W + c] = 1'b1;
            end
        end
        return f;
    endfunction

    function automatic logic [PIX_N-1:0] rand_frame(input int density);
        logic [PIX_N-1:0] f;
        for (int p = 0; p < PIX_N; p++) begin
            f[p] = (xorshift32() % 100) < density;
        end
        return f;
    endfunction

    // flood fill with 8-connectivity, then prune and keep the three largest
    function automatic void ref_ccl(input logic [PIX_N-1:0] frm, output int cnt,
                                    output int t0, output int t1, output int t2);
        bit seen [PIX_N];
        int stk  [PIX_N];
        int sp;
        int area;
        int p;
        int rr;
        int cc;
        int q;
        cnt = 0;
        t0  = 0;
        t1  = 0;
        t2  = 0;
        for (int i = 0; i < PIX_N; i++) begin
            seen[i] = 1'b0;
        end
        for (int s = 0; s < PIX_N; s++) begin
            if (frm[s] && !seen[s]) begin
                seen[s] = 1'b1;
                stk[0]  = s;
                sp      = 1;
                area    = 0;
                while (sp > 0) begin
                    sp--;
                    p = stk[sp];
                    area++;
                    for (int dr = -1; dr <= 1; dr++) begin
                        for (int dc = -1; dc <= 1; dc++) begin
                            rr = p / `CCL_IMG_W + dr;
                            cc = p % `CCL_IMG_W + dc;
                            q  = rr * `CCL_IMG_W + cc;
                            if (rr >= 0 && rr < `CCL_IMG_H && cc >= 0 && cc < `CCL_IMG_W
                                    && frm[q] && !seen[q]) begin
                                seen[q] = 1'b1;  // marked on push, so each pixel goes once
                                stk[sp] = q;
                                sp++;
                            end
                        end
                    end
                end
                if (area >= `CCL_MIN_AREA) begin
                    cnt++;
                    if (area > t0) begin
                        t2 = t1;
                        t1 = t0;
                        t0 = area;
                    end else if (area > t1) begin
                        t2 = t1;
                        t1 = area;
                    end else if (area > t2) begin
                        t2 = area;
                    end
                end
            end
        end
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // streams one frame, with idle gaps on pix_valid at the given rate
    task automatic send_frame(input logic [PIX_N-1:0] f, input int gap_pct);
        int e_cnt;
        int e0;
        int e1;
        int e2;
        ref_ccl(f, e_cnt, e0, e1, e2);
        exp_q.push_back(e_cnt);
        exp_q.push_back(e0);
        exp_q.push_back(e1);
        exp_q.push_back(e2);
        sent_frames++;
        frame_start <= 1'b1;
        @(posedge clk_in);
        frame_start <= 1'b0;
        for (int p = 0; p < PIX_N; p++) begin
            if (gap_pct > 0 && (xorshift32() % 100) < gap_pct) begin
                pix_valid <= 1'b0;
                repeat (1 + xorshift32() % 3) @(posedge clk_in);
            end
            pix_valid <= 1'b1;
            pix_mask  <= f[p];
            @(posedge clk_in);
            check_value("pix_ready while streaming", pix_ready, 1);
        end
        pix_valid <= 1'b0;
        pix_mask  <= 1'b0;
    endtask

    task automatic wait_result();
        @(posedge clk_in);
        while (!done) begin
            @(posedge clk_in);
        end
        wait (checked_frames == sent_frames);
    endtask

    task automatic run_frame(input logic [PIX_N-1:0] f, input int gap_pct);
        send_frame(f, gap_pct);
        wait_result();
    endtask

    task automatic finish_test(input string name);
        $display("test %s: %0d frames, %0d errors", name, sent_frames - frame_base,
                 err_count - err_base);
        frame_base = sent_frames;
        err_base   = err_count;
    endtask

    initial begin : compare_results
        logic busy_q;  // busy one edge earlier
        busy_q = 1'b0;
        forever begin
            @(posedge clk_in);
            if (done) begin
                if (exp_q.size() < 4) begin
                    err_count++;
                    $display("done pulsed at %0t with no frame outstanding", $time);
                end else begin
                    check_value("blob_count", blob_count, exp_q.pop_front());
                    check_value("top_area[0]", top_area[0], exp_q.pop_front());
                    check_value("top_area[1]", top_area[1], exp_q.pop_front());
                    check_value("top_area[2]", top_area[2], exp_q.pop_front());
                    check_value("busy at done", busy, 0);
                    check_value("busy before done", busy_q, 1);
                end
                checked_frames++;
            end
            busy_q = busy;
        end
    end

    initial begin : stimulus
        logic [PIX_N-1:0] f;
        rst_in      = 1'b1;
        frame_start = 1'b0;
        pix_valid   = 1'b0;
        pix_mask    = 1'b0;
        repeat (5) @(posedge clk_in);
        rst_in <= 1'b0;
        @(posedge clk_in);
        check_value("busy after reset", busy, 0);
        check_value("done after reset", done, 0);
        check_value("pix_ready after reset", pix_ready, 0);
        check_value("blob_count after reset", blob_count, 0);
        check_value("top_area[0] after reset", top_area[0], 0);
        check_value("top_area[1] after reset", top_area[1], 0);
        check_value("top_area[2] after reset", top_area[2], 0);
        finish_test("reset");

        run_frame('0, 0);
        finish_test("empty_frame");

        run_frame(add_rect('0, 3, 4, 4, 6), 0);
        f = '0;
        for (int i = 0; i < 5; i++) begin
            f = add_rect(f, 2 + i, 3 + i, 1, 1);   // north-west steps
        end
        run_frame(f, 0);
        f = '0;
        for (int i = 0; i < 5; i++) begin
            f = add_rect(f, 2 + i, 12 - i, 1, 1);  // north-east steps
        end
        run_frame(f, 0);
        finish_test("rect_diagonal");

        f = add_rect('0, 1, 2, 6, 1);
        f = add_rect(f, 1, 6, 6, 1);
        f = add_rect(f, 6, 2, 1, 5);
        run_frame(f, 0);
        f = add_rect('0, 3, 2, 6, 1);
        f = add_rect(f, 5, 5, 4, 1);
        f = add_rect(f, 3, 8, 6, 1);
        f = add_rect(f, 8, 2, 1, 7);
        run_frame(f, 0);
        finish_test("u_w_merge");

        // specks only, all under the minimum area
        f = add_rect('0, 1, 1, 1, 1);
        f = add_rect(f, 1, 5, 1, 2);
        f = add_rect(f, 5, 10, 1, 2);
        f = add_rect(f, 6, 10, 1, 1);
        f = add_rect(f, 9, 3, 1, 1);
        run_frame(f, 0);
        f = add_rect('0, 0, 0, 2, 2);
        f = add_rect(f, 0, 5, 3, 3);
        f = add_rect(f, 0, 11, 2, 3);
        f = add_rect(f, 5, 0, 3, 4);
        f = add_rect(f, 9, 8, 1, 5);
        run_frame(f, 0);
        finish_test("prune_rank");

        for (int i = 0; i < 20; i++) begin
            run_frame(rand_frame(20 + (40 * i) / 19), 25);
        end
        finish_test("random");

        send_frame(rand_frame(35), 0);
        frame_start <= 1'b1;  // lands while the frame is labeled
        @(posedge clk_in);
        frame_start <= 1'b0;
        check_value("busy at extra frame_start", busy, 1);
        wait_result();
        repeat (4) @(posedge clk_in);
        check_value("pix_ready after ignored start", pix_ready, 0);
        check_value("busy after ignored start", busy, 0);
        run_frame(add_rect('0, 0, 0, 3, 3), 0);
        run_frame(rand_frame(50), 0);
        finish_test("busy_start");

        $display("%0d checks over %0d frames, %0d errors", check_count, checked_frames,
                 err_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+include
source/ccl_pkg.sv
source/label_ram.sv
source/scan_counter.sv
source/ccl_ctrl.sv
source/neighbor_labeler.sv
source/area_accum.sv
source/blob_ranker.sv
source/ccl_top.sv
sim/tb_ccl.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_ccl
FILELIST   := vlog.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)
SOURCES    := $(wildcard include/*.svh source/*.sv sim/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, a missing final line also counts as failure
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "no final result in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
